// File: src/u2_ctrl_pkg.sv
/*
 * Shared definitions for the radio control core
 *  - settings bus and readback word types
 *  - VITA time and LED vector types
 *  - settings register map and readback word indices
 *  - compatibility number and LED source reset value
 */
package u2_ctrl_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   // Seconds in the upper word, ticks in the lower word
   typedef logic [63:0] vita_time_t;
   typedef logic [7:0]  led_t;
   typedef logic [3:0]  rb_index_t;
   typedef logic [1:0]  axi_resp_t;

   // AXI4-Lite byte address width
   localparam int AXI_ADDR_W = 10;
   localparam axi_resp_t RESP_OKAY = 2'b00;

   ////////////////////
   // Settings register map
   localparam set_addr_t SR_MISC   = 8'd0;   // 7 regs
   localparam set_addr_t SR_TIME64 = 8'd10;  // 3 regs

   ////////////////////
   // Readback word indices
   localparam rb_index_t RB_TIME_HI = 4'd10;
   localparam rb_index_t RB_TIME_LO = 4'd11;
   localparam rb_index_t RB_COMPAT  = 4'd12;
   localparam rb_index_t RB_STATUS  = 4'd13;
   localparam rb_index_t RB_PPS_HI  = 4'd14;
   localparam rb_index_t RB_PPS_LO  = 4'd15;

   // Major 9, minor 0
   localparam set_data_t COMPAT_NUM = {16'd9, 16'd0};

   // Hardware drives run and clock status LEDs out of reset
   localparam led_t LED_SRC_RESET = 8'b0001_1110;

endpackage

// File: src/axil_settings_slave.sv
/*
 * AXI4-Lite slave for the settings bus
 *  - writes become one-cycle settings strobes
 *  - reads go through the registered readback mux
 *  - responses held under back-pressure
 */
`timescale 1ns/1ns

module axil_settings_slave import u2_ctrl_pkg::*; (
   input  logic                  dsp_clk,
   input  logic                  rst_n_i,
   input  logic [AXI_ADDR_W-1:0] s_axi_awaddr_i,
   input  logic                  s_axi_awvalid_i,
   output logic                  s_axi_awready_o,
   input  set_data_t             s_axi_wdata_i,
   input  logic                  s_axi_wvalid_i,
   output logic                  s_axi_wready_o,
   output logic                  s_axi_bvalid_o,
   output axi_resp_t             s_axi_bresp_o,
   input  logic                  s_axi_bready_i,
   input  logic [AXI_ADDR_W-1:0] s_axi_araddr_i,
   input  logic                  s_axi_arvalid_i,
   output logic                  s_axi_arready_o,
   output logic                  s_axi_rvalid_o,
   output set_data_t             s_axi_rdata_o,
   output axi_resp_t             s_axi_rresp_o,
   input  logic                  s_axi_rready_i,
   input  set_data_t             rb_data_i,
   output logic                  set_stb_o,
   output set_addr_t             set_addr_o,
   output set_data_t             set_data_o,
   output rb_index_t             rb_index_o
);

   typedef enum logic [1:0] {IDLE, WRITE_RESP, READ_WAIT, READ_RESP} state_t;

   state_t    state_q;
   logic      wr_start;
   logic      rd_start;
   set_data_t rdata_q;
   logic      rdata_held_q;

   // Write wins when both channels are ready to go
   assign wr_start = (state_q == IDLE) && s_axi_awvalid_i && s_axi_wvalid_i;
   assign rd_start = (state_q == IDLE) && !(s_axi_awvalid_i && s_axi_wvalid_i) &&
                     s_axi_arvalid_i;

   assign s_axi_awready_o = wr_start;
   assign s_axi_wready_o  = wr_start;
   assign s_axi_arready_o = rd_start;
   assign s_axi_bvalid_o  = (state_q == WRITE_RESP);
   assign s_axi_bresp_o   = RESP_OKAY;
   assign s_axi_rvalid_o  = (state_q == READ_RESP);
   assign s_axi_rresp_o   = RESP_OKAY;

   // Mux output keeps moving for time words, so freeze it while stalled
   assign s_axi_rdata_o = rdata_held_q ? rdata_q : rb_data_i;

   ////////////////////
   // Control FSM
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         state_q      <= IDLE;
         set_stb_o    <= 1'b0;
         rb_index_o   <= '0;
         rdata_held_q <= 1'b0;
      end else begin
         set_stb_o <= wr_start;
         case (state_q)
            IDLE: begin
               rdata_held_q <= 1'b0;
               if (wr_start) begin
                  state_q <= WRITE_RESP;
               end else if (rd_start) begin
                  state_q    <= READ_WAIT;
                  rb_index_o <= s_axi_araddr_i[5:2];
               end
            end
            WRITE_RESP: begin
               if (s_axi_bready_i)
                  state_q <= IDLE;
            end
            // Mux registers the selected word here
            READ_WAIT: state_q <= READ_RESP;
            READ_RESP: begin
               if (s_axi_rready_i) begin
                  state_q      <= IDLE;
                  rdata_held_q <= 1'b0;
               end else begin
                  rdata_held_q <= 1'b1;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   ////////////////////
   // Payload registers
   always_ff @(posedge dsp_clk) begin
      if (wr_start) begin
         set_addr_o <= s_axi_awaddr_i[AXI_ADDR_W-1:2];
         set_data_o <= s_axi_wdata_i;
      end
      if (state_q == READ_RESP && !rdata_held_q)
         rdata_q <= rb_data_i;
   end

endmodule

// File: src/vita_timer.sv
/*
 * 64-bit VITA time counter
 *  - seconds and ticks, ticks wrap at TICKS_PER_SEC
 *  - staged load applied at once or on the next PPS edge
 *  - time captured at every PPS edge
 */
`timescale 1ns/1ns

module vita_timer import u2_ctrl_pkg::*; #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100_000_000
) (
   input  logic       dsp_clk,
   input  logic       rst_n_i,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o
);

   logic [31:0] secs_q;
   logic [31:0] ticks_q;
   logic [31:0] secs_stage_q;
   logic [31:0] ticks_stage_q;
   vita_time_t  staged;
   logic [2:0]  pps_sync_q;
   logic        pps_edge;
   logic        commit;
   logic        load_armed_q;

   assign vita_time_o = {secs_q, ticks_q};
   assign staged      = {secs_stage_q, ticks_stage_q};

   // Two sync flops, third one for the edge
   assign pps_edge = pps_sync_q[1] & ~pps_sync_q[2];
   assign commit   = set_stb_i && (set_addr_i == SR_TIME64 + 8'd2);

   // Staged time
   always_ff @(posedge dsp_clk) begin
      if (set_stb_i && set_addr_i == SR_TIME64)
         secs_stage_q <= set_data_i;
      if (set_stb_i && set_addr_i == SR_TIME64 + 8'd1)
         ticks_stage_q <= set_data_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         pps_sync_q      <= '0;
         secs_q          <= '0;
         ticks_q         <= '0;
         vita_time_pps_o <= '0;
         load_armed_q    <= 1'b0;
      end else begin
         pps_sync_q <= {pps_sync_q[1:0], pps_i};

         if (commit && set_data_i[0]) begin
            {secs_q, ticks_q} <= staged;
         end else if (pps_edge && load_armed_q) begin
            {secs_q, ticks_q} <= staged;
         end else if (ticks_q == TICKS_PER_SEC - 1) begin
            ticks_q <= '0;
            secs_q  <= secs_q + 32'd1;
         end else begin
            ticks_q <= ticks_q + 32'd1;
         end

         // Armed edge reports the loaded time
         if (pps_edge)
            vita_time_pps_o <= load_armed_q ? staged : vita_time_o;

         if (commit)
            load_armed_q <= ~set_data_i[0];
         else if (pps_edge)
            load_armed_q <= 1'b0;
      end
   end

endmodule

// File: src/misc_settings.sv
/*
 * Miscellaneous setting registers
 *  - clock generator, serializer and converter control
 *  - phy reset, software LEDs and LED source select
 */
`timescale 1ns/1ns

module misc_settings import u2_ctrl_pkg::*; (
   input  logic       dsp_clk,
   input  logic       rst_n_i,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       run_rx_i,
   input  logic       run_tx_i,
   input  logic       clk_status_i,
   output led_t       leds_o,
   output logic [4:0] clk_ctrl_o,
   output logic [3:0] ser_ctrl_o,
   output logic [3:0] adc_ctrl_o,
   output logic       phy_reset_n_o
);

   led_t led_sw_q;
   led_t led_src_q;
   led_t led_hw;
   logic phy_reset_q;

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         clk_ctrl_o  <= '0;
         ser_ctrl_o  <= '0;
         adc_ctrl_o  <= '0;
         led_sw_q    <= '0;
         phy_reset_q <= 1'b0;
         led_src_q   <= LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_MISC + 8'd0: clk_ctrl_o  <= set_data_i[4:0];
            SR_MISC + 8'd1: ser_ctrl_o  <= set_data_i[3:0];
            SR_MISC + 8'd2: adc_ctrl_o  <= set_data_i[3:0];
            SR_MISC + 8'd3: led_sw_q    <= set_data_i[7:0];
            SR_MISC + 8'd4: phy_reset_q <= set_data_i[0];
            SR_MISC + 8'd6: led_src_q   <= set_data_i[7:0];
            default: ;
         endcase
      end
   end

   assign phy_reset_n_o = ~phy_reset_q;

   ////////////////////
   // LEDs, source bit 1 = hardware, 0 = software
   // Bit 1 is the serializer link LED, dark without the link
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, 2'b00};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

// File: src/readback_mux.sv
/*
 * Registered readback select over 16 words
 */
`timescale 1ns/1ns

module readback_mux import u2_ctrl_pkg::*; (
   input  logic       dsp_clk,
   input  logic       rst_n_i,
   input  rb_index_t  rb_index_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i,
   input  logic       clk_status_i,
   output set_data_t  rb_data_o
);

   set_data_t status_word;

   // Bit 10 would be serializer link up
   assign status_word = {20'd0, clk_status_i, 1'b0, 10'd0};

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         rb_data_o <= '0;
      end else begin
         case (rb_index_i)
            RB_TIME_HI: rb_data_o <= vita_time_i[63:32];
            RB_TIME_LO: rb_data_o <= vita_time_i[31:0];
            RB_COMPAT:  rb_data_o <= COMPAT_NUM;
            RB_STATUS:  rb_data_o <= status_word;
            RB_PPS_HI:  rb_data_o <= vita_time_pps_i[63:32];
            RB_PPS_LO:  rb_data_o <= vita_time_pps_i[31:0];
            // Words 0 to 9 are unused
            default:    rb_data_o <= '0;
         endcase
      end
   end

endmodule

// File: src/u2_ctrl_core.sv
/*
 * Control plane top level
 *  - AXI4-Lite settings slave
 *  - VITA time counter
 *  - misc setting registers and LED mux
 *  - readback mux
 */
`timescale 1ns/1ns

module u2_ctrl_core import u2_ctrl_pkg::*; #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100_000_000
) (
   input  logic                  dsp_clk,
   input  logic                  rst_n_i,
   input  logic [AXI_ADDR_W-1:0] s_axi_awaddr_i,
   input  logic                  s_axi_awvalid_i,
   output logic                  s_axi_awready_o,
   input  set_data_t             s_axi_wdata_i,
   input  logic                  s_axi_wvalid_i,
   output logic                  s_axi_wready_o,
   output logic                  s_axi_bvalid_o,
   output axi_resp_t             s_axi_bresp_o,
   input  logic                  s_axi_bready_i,
   input  logic [AXI_ADDR_W-1:0] s_axi_araddr_i,
   input  logic                  s_axi_arvalid_i,
   output logic                  s_axi_arready_o,
   output logic                  s_axi_rvalid_o,
   output set_data_t             s_axi_rdata_o,
   output axi_resp_t             s_axi_rresp_o,
   input  logic                  s_axi_rready_i,
   input  logic                  pps_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic                  clk_status_i,
   output led_t                  leds_o,
   output logic [4:0]            clk_ctrl_o,
   output logic [3:0]            ser_ctrl_o,
   output logic [3:0]            adc_ctrl_o,
   output logic                  phy_reset_n_o
);

   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   rb_index_t  rb_index;
   set_data_t  rb_data;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   ////////////////////
   // Settings bus
   axil_settings_slave axil_settings_slave_i (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .s_axi_awaddr_i(s_axi_awaddr_i), .s_axi_awvalid_i(s_axi_awvalid_i),
      .s_axi_awready_o(s_axi_awready_o),
      .s_axi_wdata_i(s_axi_wdata_i), .s_axi_wvalid_i(s_axi_wvalid_i),
      .s_axi_wready_o(s_axi_wready_o),
      .s_axi_bvalid_o(s_axi_bvalid_o), .s_axi_bresp_o(s_axi_bresp_o),
      .s_axi_bready_i(s_axi_bready_i),
      .s_axi_araddr_i(s_axi_araddr_i), .s_axi_arvalid_i(s_axi_arvalid_i),
      .s_axi_arready_o(s_axi_arready_o),
      .s_axi_rvalid_o(s_axi_rvalid_o), .s_axi_rdata_o(s_axi_rdata_o),
      .s_axi_rresp_o(s_axi_rresp_o), .s_axi_rready_i(s_axi_rready_i),
      .rb_data_i(rb_data),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .rb_index_o(rb_index)
   );

   ////////////////////
   // Timing and settings
   vita_timer #(.TICKS_PER_SEC(TICKS_PER_SEC)) vita_timer_i (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps)
   );

   misc_settings misc_settings_i (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i), .clk_status_i(clk_status_i),
      .leds_o(leds_o), .clk_ctrl_o(clk_ctrl_o), .ser_ctrl_o(ser_ctrl_o),
      .adc_ctrl_o(adc_ctrl_o), .phy_reset_n_o(phy_reset_n_o)
   );

   readback_mux readback_mux_i (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .rb_index_i(rb_index),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .clk_status_i(clk_status_i), .rb_data_o(rb_data)
   );

endmodule

// File: tb/tb_u2_ctrl_core.sv
/*
 * Testbench for the control plane top level
 *  - AXI4-Lite write and read driver tasks
 *  - typed compare tasks and LED select model
 *  - directed tests for misc registers, LEDs, VITA time and back-pressure
 */
`timescale 1ns/1ns

module tb_u2_ctrl_core import u2_ctrl_pkg::*; ();

   localparam int MAX_CYCLES = 3000;
   localparam int SAMPLE_DLY = 2;

   logic dsp_clk = 1'b0;
   logic rst_n_i;
   logic [AXI_ADDR_W-1:0] s_axi_awaddr_i, s_axi_araddr_i;
   logic s_axi_awvalid_i, s_axi_wvalid_i, s_axi_bready_i, s_axi_arvalid_i, s_axi_rready_i;
   set_data_t s_axi_wdata_i, s_axi_rdata_o;
   logic s_axi_awready_o, s_axi_wready_o, s_axi_bvalid_o, s_axi_arready_o, s_axi_rvalid_o;
   axi_resp_t s_axi_bresp_o, s_axi_rresp_o;
   logic pps_i, run_rx_i, run_tx_i, clk_status_i, phy_reset_n_o;
   led_t leds_o;
   logic [4:0] clk_ctrl_o;
   logic [3:0] ser_ctrl_o, adc_ctrl_o;

   int    errors = 0;
   int    checks = 0;
   int    test_errs = 0;
   int    cycle_cnt = 0;
   string waiting_for = "reset release";

   u2_ctrl_core #(.TICKS_PER_SEC(32'd100)) u2_ctrl_core_i (.*);

   always #10 dsp_clk = ~dsp_clk;

   // Hang guard
   always @(posedge dsp_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, %s never came", cycle_cnt, waiting_for);
         $display("Errors found");
         $finish;
      end
   end

   ////////////////////
   // Compare tasks
   task automatic fail_msg(input string what);
      errors++;
      $display("Error at %0t ns: %s", $time, what);
   endtask

   task automatic check_data(input string name, input set_data_t got, input set_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_leds(input string name, input led_t got, input led_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   // Hardware bit wherever the source bit is set
   function automatic led_t led_expect(led_t sw, led_t src, logic rx, logic tx, logic st);
      led_t hw;
      led_t res;
      hw    = '0;
      hw[4] = tx;
      hw[3] = rx;
      hw[2] = st;
      for (int i = 0; i < 8; i++)
         res[i] = src[i] ? hw[i] : sw[i];
      return res;
   endfunction

   ////////////////////
   // AXI4-Lite driver
   task automatic wait_high(ref logic sig, input string what);
      waiting_for = what;
      #SAMPLE_DLY;
      while (!sig) begin
         @(negedge dsp_clk);
         #SAMPLE_DLY;
      end
   endtask

   task automatic axil_write(input set_addr_t addr, input set_data_t data);
      @(negedge dsp_clk);
      s_axi_awaddr_i  = {addr, 2'b00};
      s_axi_wdata_i   = data;
      s_axi_awvalid_i = 1'b1;
      s_axi_wvalid_i  = 1'b1;
      wait_high(s_axi_awready_o, "write address and data handshake");
      checks++;
      if (!s_axi_wready_o)
         fail_msg("wready did not rise together with awready");
      @(negedge dsp_clk);
      s_axi_awvalid_i = 1'b0;
      s_axi_wvalid_i  = 1'b0;
      wait_high(s_axi_bvalid_o, "write response");
      check_resp("s_axi_bresp_o", s_axi_bresp_o, RESP_OKAY);
   endtask

   task automatic axil_read(input rb_index_t idx, input int stall, output set_data_t data);
      @(negedge dsp_clk);
      s_axi_araddr_i  = {4'd0, idx, 2'b00};
      s_axi_arvalid_i = 1'b1;
      s_axi_rready_i  = (stall == 0);
      wait_high(s_axi_arready_o, "read address handshake");
      @(negedge dsp_clk);
      s_axi_arvalid_i = 1'b0;
      wait_high(s_axi_rvalid_o, "read data valid");
      data = s_axi_rdata_o;
      check_resp("s_axi_rresp_o", s_axi_rresp_o, RESP_OKAY);
      if (stall > 0) begin
         repeat (stall) begin
            @(negedge dsp_clk);
            #SAMPLE_DLY;
            checks++;
            if (!s_axi_rvalid_o)
               fail_msg("rvalid dropped while rready was low");
            check_data("s_axi_rdata_o", s_axi_rdata_o, data);
         end
         @(negedge dsp_clk);
         s_axi_rready_i = 1'b1;
         @(negedge dsp_clk);
         #SAMPLE_DLY;
         checks++;
         if (s_axi_rvalid_o)
            fail_msg("read data was not accepted after rready rose");
      end
   endtask

   task automatic report_test(input string name);
      $display("%s finished with %0d errors", name, errors - test_errs);
      test_errs = errors;
   endtask

   ////////////////////
   // Directed tests
   task automatic test_reset_defaults();
      set_data_t rd;
      check_leds("leds_o", leds_o, led_expect(8'h00, LED_SRC_RESET, 1'b0, 1'b0, 1'b0));
      check_data("clk_ctrl_o", 32'(clk_ctrl_o), 32'd0);
      check_data("ser_ctrl_o", 32'(ser_ctrl_o), 32'd0);
      check_data("adc_ctrl_o", 32'(adc_ctrl_o), 32'd0);
      check_data("phy_reset_n_o", 32'(phy_reset_n_o), 32'd1);
      axil_read(RB_COMPAT, 0, rd);
      check_data("RB_COMPAT", rd, COMPAT_NUM);
      report_test("Reset defaults");
   endtask

   task automatic test_misc_regs();
      set_data_t clk_v, ser_v, adc_v, phy_v;
      clk_v = $urandom;
      ser_v = $urandom;
      adc_v = $urandom;
      phy_v = $urandom | 32'd1;
      axil_write(SR_MISC + 8'd0, clk_v);
      axil_write(SR_MISC + 8'd1, ser_v);
      axil_write(SR_MISC + 8'd2, adc_v);
      axil_write(SR_MISC + 8'd4, phy_v);
      repeat (2) @(negedge dsp_clk);
      #SAMPLE_DLY;
      check_data("clk_ctrl_o", 32'(clk_ctrl_o), {27'd0, clk_v[4:0]});
      check_data("ser_ctrl_o", 32'(ser_ctrl_o), {28'd0, ser_v[3:0]});
      check_data("adc_ctrl_o", 32'(adc_ctrl_o), {28'd0, adc_v[3:0]});
      check_data("phy_reset_n_o", 32'(phy_reset_n_o), {31'd0, ~phy_v[0]});
      report_test("Misc registers");
   endtask

   task automatic test_led_mux();
      led_t      sw, src;
      set_data_t rd;
      sw  = led_t'($urandom);
      src = led_t'($urandom);
      @(negedge dsp_clk);
      run_rx_i     = 1'($urandom);
      run_tx_i     = 1'($urandom);
      clk_status_i = 1'($urandom);
      axil_write(SR_MISC + 8'd3, 32'(sw));
      axil_write(SR_MISC + 8'd6, 32'(src));
      repeat (2) @(negedge dsp_clk);
      #SAMPLE_DLY;
      check_leds("leds_o", leds_o, led_expect(sw, src, run_rx_i, run_tx_i, clk_status_i));
      axil_read(RB_STATUS, 0, rd);
      check_data("RB_STATUS", rd, 32'(clk_status_i) << 11);
      report_test("LED mux");
   endtask

   task automatic test_time_load();
      set_data_t rd;
      axil_write(SR_TIME64 + 8'd0, 32'd5);
      axil_write(SR_TIME64 + 8'd1, 32'd0);
      axil_write(SR_TIME64 + 8'd2, 32'd1);
      axil_read(RB_TIME_HI, 0, rd);
      check_data("RB_TIME_HI", rd, 32'd5);
      // One second is 100 ticks here
      repeat (150) @(negedge dsp_clk);
      axil_read(RB_TIME_HI, 0, rd);
      check_data("RB_TIME_HI", rd, 32'd6);
      axil_read(RB_TIME_LO, 0, rd);
      checks++;
      if (rd >= 32'd100)
         fail_msg($sformatf("ticks read %0d, not below one second", rd));
      report_test("Time load and rollover");
   endtask

   task automatic test_pps_load();
      set_data_t rd;
      axil_write(SR_TIME64 + 8'd0, 32'd40);
      axil_write(SR_TIME64 + 8'd1, 32'd7);
      axil_write(SR_TIME64 + 8'd2, 32'd0);
      axil_read(RB_TIME_HI, 0, rd);
      checks++;
      if (rd >= 32'd40)
         fail_msg("armed load applied before any PPS edge");
      @(negedge dsp_clk);
      pps_i = 1'b1;
      repeat (4) @(negedge dsp_clk);
      pps_i = 1'b0;
      axil_read(RB_PPS_HI, 0, rd);
      check_data("RB_PPS_HI", rd, 32'd40);
      axil_read(RB_PPS_LO, 0, rd);
      check_data("RB_PPS_LO", rd, 32'd7);
      axil_read(RB_TIME_HI, 0, rd);
      check_data("RB_TIME_HI", rd, 32'd40);
      report_test("PPS timed load");
   endtask

   task automatic test_back_pressure();
      set_data_t rd;
      // Ticks move every cycle so stalled data must stay frozen
      axil_read(RB_TIME_LO, 10, rd);
      report_test("Read back-pressure");
   endtask

   initial begin
      void'($urandom(32'hf09970a4));
      rst_n_i         = 1'b0;
      s_axi_awaddr_i  = '0;
      s_axi_awvalid_i = 1'b0;
      s_axi_wdata_i   = '0;
      s_axi_wvalid_i  = 1'b0;
      s_axi_bready_i  = 1'b1;
      s_axi_araddr_i  = '0;
      s_axi_arvalid_i = 1'b0;
      s_axi_rready_i  = 1'b1;
      pps_i           = 1'b0;
      run_rx_i        = 1'b0;
      run_tx_i        = 1'b0;
      clk_status_i    = 1'b0;
      repeat (10) @(negedge dsp_clk);
      rst_n_i = 1'b1;
      @(negedge dsp_clk);
      #SAMPLE_DLY;
      test_reset_defaults();
      test_misc_regs();
      test_led_mux();
      test_time_load();
      test_pps_load();
      test_back_pressure();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

// File: verilog.f
src/u2_ctrl_pkg.sv
src/axil_settings_slave.sv
src/vita_timer.sv
src/misc_settings.sv
src/readback_mux.sv
src/u2_ctrl_core.sv
tb/tb_u2_ctrl_core.sv

// File: Bender.yml
package:
  name: u2_ctrl_core

sources:
  - src/u2_ctrl_pkg.sv
  - src/axil_settings_slave.sv
  - src/vita_timer.sv
  - src/misc_settings.sv
  - src/readback_mux.sv
  - src/u2_ctrl_core.sv
  - target: test
    files:
      - tb/tb_u2_ctrl_core.sv
